/* include/sensor_hub_cfg.svh */
`ifndef SENSOR_HUB_CFG_SVH
`define SENSOR_HUB_CFG_SVH

// Channels served by the router and gathered into one packet
`define SH_NUM_CHANNELS 4

// Window length is 2**SH_WINDOW_LOG2 samples, so averaging is a plain shift
`define SH_WINDOW_LOG2 3

// Unsigned sample width from the acquisition front end
`define SH_SAMPLE_W 16

// Flops in the sck and load synchronizers
`define SH_SYNC_STAGES 2

// One record is four 16-bit fields, 8 bytes per channel
`define SH_PACKET_BYTES (8 * `SH_NUM_CHANNELS)

`endif

/* src/sensor_hub_pkg.sv */
`default_nettype none

`include "sensor_hub_cfg.svh"

package sensor_hub_pkg;

    // Width of the channel tag, 2 bits for four channels
    localparam int CHAN_W = $clog2(`SH_NUM_CHANNELS);

    // Tagged sample as delivered by the front end
    typedef struct packed {
        logic [CHAN_W-1:0]       chan;   // Target channel
        logic [`SH_SAMPLE_W-1:0] value;  // Unsigned sample
    } sample_t;

    // Result of one window, avg in the top 16 bits
    typedef struct packed {
        logic [`SH_SAMPLE_W-1:0] avg;
        logic [`SH_SAMPLE_W-1:0] min;
        logic [`SH_SAMPLE_W-1:0] max;
        logic [`SH_SAMPLE_W-1:0] seq;  // Window count, wraps
    } chan_rec_t;

    // One record per channel, channel 0 in the most significant position
    typedef chan_rec_t [0:`SH_NUM_CHANNELS-1] chan_rec_arr_t;

    // Same 256-bit word seen as records or as wire-order bytes
    // Byte 0 is channel 0 avg high byte, the last byte is channel 3 seq low byte
    typedef union packed {
        chan_rec_arr_t                        chan;   // Written by the builder
        logic [0:`SH_PACKET_BYTES-1][7:0]     bytes;  // Read by the SPI slave
    } tx_packet_u;

endpackage

`default_nettype wire

/* src/sample_router.sv */
`timescale 1ns/10ps
`default_nettype none

`include "sensor_hub_cfg.svh"

module sample_router (
    input  logic                          clk,
    input  logic                          rst,
    input  sensor_hub_pkg::sample_t       sample_in,     // Tagged sample from front end
    input  logic                          sample_valid,  // One cycle per sample
    output logic [`SH_SAMPLE_W-1:0]       chan_value,    // Shared by all engines
    output logic [`SH_NUM_CHANNELS-1:0]   chan_strobe    // One-hot engine select
);

    // Value is broadcast and only the strobe picks the channel
    always_ff @(posedge clk) begin
        if (sample_valid) begin
            chan_value <= sample_in.value;
        end
    end

    // One-hot decode of the tag one cycle after sample_valid
    always_ff @(posedge clk) begin
        if (rst) begin
            chan_strobe <= '0;
        end else begin
            chan_strobe <= '0;  // Pulse only
            if (sample_valid && (sample_in.chan < `SH_NUM_CHANNELS)) begin
                chan_strobe[sample_in.chan] <= 1'b1;
            end
        end
    end

    // A valid sample carries a legal channel tag
    a_valid_chan : assert property (
        @(posedge clk) disable iff (rst)
        sample_valid |-> (sample_in.chan < `SH_NUM_CHANNELS)
    ) else $error("sample_router: channel tag out of range");

endmodule

`default_nettype wire

/* src/channel_stats.sv */
`timescale 1ns/10ps
`default_nettype none

`include "sensor_hub_cfg.svh"

module channel_stats (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [`SH_SAMPLE_W-1:0]     value,      // Sample from the router
    input  logic                        strobe,     // This channel's sample strobe
    output sensor_hub_pkg::chan_rec_t   rec,        // Last finished window
    output logic                        rec_valid   // Pulse after the eighth sample
);

    // Sum of a full window needs SH_WINDOW_LOG2 extra bits
    localparam int SUM_W = `SH_SAMPLE_W + `SH_WINDOW_LOG2;

    logic [SUM_W-1:0]           sum;
    logic [`SH_SAMPLE_W-1:0]    min_q;
    logic [`SH_SAMPLE_W-1:0]    max_q;
    logic [`SH_WINDOW_LOG2-1:0] count;     // Samples taken in this window
    logic [`SH_SAMPLE_W-1:0]    seq;       // Number of the window in progress
    logic [SUM_W-1:0]           sum_next;
    logic [`SH_SAMPLE_W-1:0]    min_next;
    logic [`SH_SAMPLE_W-1:0]    max_next;
    logic                       first;
    logic                       last;

    assign first = (count == '0);  // Sample seeds sum, min and max
    assign last  = (count == '1);  // Sample closes the window

    // Values including the current sample
    always_comb begin
        sum_next = first ? SUM_W'(value) : sum + SUM_W'(value);
        min_next = (first || (value < min_q)) ? value : min_q;
        max_next = (first || (value > max_q)) ? value : max_q;
    end

    // Running accumulators, valid only while count is nonzero
    always_ff @(posedge clk) begin
        if (strobe) begin
            sum   <= sum_next;
            min_q <= min_next;
            max_q <= max_next;
        end
    end

    // Count wraps to zero after the last sample, next strobe starts fresh
    always_ff @(posedge clk) begin
        if (rst) begin
            count     <= '0;
            seq       <= '0;
            rec_valid <= 1'b0;
        end else begin
            rec_valid <= strobe && last;
            if (strobe) begin
                count <= count + 1'b1;
                if (last) begin
                    seq <= seq + 1'b1;
                end
            end
        end
    end

    // Record fields captured on the closing sample
    always_ff @(posedge clk) begin
        if (strobe && last) begin
            rec.avg <= sum_next[SUM_W-1:`SH_WINDOW_LOG2];  // Divide by window length
            rec.min <= min_next;
            rec.max <= max_next;
            rec.seq <= seq;
        end
    end

    // Average of a window must sit between its extremes
    a_rec_order : assert property (
        @(posedge clk) disable iff (rst)
        rec_valid |-> (rec.min <= rec.avg) && (rec.avg <= rec.max)
    ) else $error("channel_stats: min/avg/max out of order");

endmodule

`default_nettype wire

/* src/packet_builder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "sensor_hub_cfg.svh"

module packet_builder (
    input  logic                            clk,
    input  logic                            rst,
    input  sensor_hub_pkg::chan_rec_arr_t   rec,             // One record per engine
    input  logic [`SH_NUM_CHANNELS-1:0]     rec_valid,       // Record pulses
    input  logic                            packet_taken,    // From the SPI slave
    output sensor_hub_pkg::tx_packet_u      packet,          // Held while packet_valid
    output logic                            packet_valid,
    output logic                            overwrite_pulse  // Held record was replaced
);

    sensor_hub_pkg::chan_rec_arr_t   slot;     // Newest record per channel
    logic [`SH_NUM_CHANNELS-1:0]     full;     // Slot holds an unpublished record
    logic                            publish;  // Copy slots into the packet this cycle
    logic [`SH_NUM_CHANNELS-1:0]     clobber;  // Unpublished record lost

    assign publish = (&full) && !packet_valid;

    // In the publish cycle the old slot content still reaches the packet
    assign clobber = rec_valid & full & {`SH_NUM_CHANNELS{!publish}};

    // Slots always take the newest record, even while a packet waits
    always_ff @(posedge clk) begin
        for (int ch = 0; ch < `SH_NUM_CHANNELS; ch++) begin
            if (rec_valid[ch]) begin
                slot[ch] <= rec[ch];
            end
        end
    end

    // Packet is only rewritten while packet_valid is low
    always_ff @(posedge clk) begin
        if (publish) begin
            packet.chan <= slot;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            full            <= '0;
            packet_valid    <= 1'b0;
            overwrite_pulse <= 1'b0;
        end else begin
            overwrite_pulse <= |clobber;
            if (publish) begin
                full         <= rec_valid;  // Records arriving now belong to the next packet
                packet_valid <= 1'b1;
            end else begin
                full <= full | rec_valid;
                if (packet_taken) begin
                    packet_valid <= 1'b0;  // Slave has acknowledged
                end
            end
        end
    end

    // SPI slave may still be shifting, so the packet must hold until released
    a_packet_stable : assert property (
        @(posedge clk) disable iff (rst)
        packet_valid |=> $stable(packet)
    ) else $error("packet_builder: packet changed while packet_valid high");

endmodule

`default_nettype wire

/* src/spi_packet_tx.sv */
`timescale 1ns/10ps
`default_nettype none

`include "sensor_hub_cfg.svh"

module spi_packet_tx (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        sck,           // SPI clock from the MCU, mode 0
    input  logic                        load,          // Rising edge acknowledges the packet
    output logic                        sdo,           // MISO
    output logic                        done,          // Packet ready for the MCU
    input  sensor_hub_pkg::tx_packet_u  packet,        // From the builder
    input  logic                        packet_valid,
    output logic                        packet_taken   // One pulse per acknowledge
);

    localparam int BYTE_IDX_W = $clog2(`SH_PACKET_BYTES);
    localparam logic [BYTE_IDX_W-1:0] LAST_BYTE = BYTE_IDX_W'(`SH_PACKET_BYTES - 1);

    logic [`SH_SYNC_STAGES-1:0] sck_sync;
    logic [`SH_SYNC_STAGES-1:0] load_sync;
    logic                       sck_prev;   // For edge detect after the synchronizer
    logic                       load_prev;
    logic                       sck_fall;
    logic                       load_rise;
    sensor_hub_pkg::tx_packet_u tx_buf;     // Copy being shifted out
    logic [BYTE_IDX_W-1:0]      byte_idx;   // Byte on the wire
    logic [2:0]                 bit_idx;    // 7 is sent first
    logic                       drained;    // All 256 bits gone

    // sck and load are asynchronous to clk
    always_ff @(posedge clk) begin
        if (rst) begin
            sck_sync  <= '0;
            load_sync <= '0;
            sck_prev  <= 1'b0;
            load_prev <= 1'b0;
        end else begin
            sck_sync  <= {sck_sync[`SH_SYNC_STAGES-2:0], sck};
            load_sync <= {load_sync[`SH_SYNC_STAGES-2:0], load};
            sck_prev  <= sck_sync[`SH_SYNC_STAGES-1];
            load_prev <= load_sync[`SH_SYNC_STAGES-1];
        end
    end

    assign sck_fall  = sck_prev && !sck_sync[`SH_SYNC_STAGES-1];   // Mode 0 shift edge
    assign load_rise = !load_prev && load_sync[`SH_SYNC_STAGES-1];

    // Latch a waiting packet
    // packet_valid is still high in the cycle of packet_taken, so that cycle is skipped
    always_ff @(posedge clk) begin
        if (!done && packet_valid && !packet_taken) begin
            tx_buf <= packet;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            done         <= 1'b0;
            packet_taken <= 1'b0;
            byte_idx     <= '0;
            bit_idx      <= 3'd7;
            drained      <= 1'b0;
        end else begin
            packet_taken <= 1'b0;
            if (!done) begin
                if (packet_valid && !packet_taken) begin
                    done     <= 1'b1;
                    byte_idx <= '0;      // First bit shows up as done rises
                    bit_idx  <= 3'd7;
                    drained  <= 1'b0;
                end
            end else if (load_rise) begin
                done         <= 1'b0;    // MCU acknowledged
                packet_taken <= 1'b1;
            end else if (sck_fall && !drained) begin
                if (bit_idx != 3'd0) begin
                    bit_idx <= bit_idx - 1'b1;
                end else if (byte_idx == LAST_BYTE) begin
                    drained <= 1'b1;     // Extra edges shift zeros
                end else begin
                    byte_idx <= byte_idx + 1'b1;
                    bit_idx  <= 3'd7;
                end
            end
        end
    end

    // Current bit straight from the byte view, low when idle or drained
    assign sdo = done && !drained && tx_buf.bytes[byte_idx][bit_idx];

    // Only an acknowledge ends a transfer
    a_done_fall : assert property (
        @(posedge clk) disable iff (rst)
        $fell(done) |-> packet_taken
    ) else $error("spi_packet_tx: done fell without packet_taken");

endmodule

`default_nettype wire

/* src/sensor_hub_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "sensor_hub_cfg.svh"

module sensor_hub_top (
    input  logic                     clk,
    input  logic                     rst,
    input  sensor_hub_pkg::sample_t  sample_in,
    input  logic                     sample_valid,
    input  logic                     sck,
    input  logic                     load,
    output logic                     sdo,
    output logic                     done,
    output logic                     overwrite_pulse
);

    logic [`SH_SAMPLE_W-1:0]        chan_value;    // Broadcast sample
    logic [`SH_NUM_CHANNELS-1:0]    chan_strobe;
    sensor_hub_pkg::chan_rec_arr_t  rec;           // Engine results
    logic [`SH_NUM_CHANNELS-1:0]    rec_valid;
    sensor_hub_pkg::tx_packet_u     packet;
    logic                           packet_valid;
    logic                           packet_taken;

    sample_router u_router (
        .clk          (clk),
        .rst          (rst),
        .sample_in    (sample_in),
        .sample_valid (sample_valid),
        .chan_value   (chan_value),
        .chan_strobe  (chan_strobe)
    );

    // One statistics engine per channel
    for (genvar ch = 0; ch < `SH_NUM_CHANNELS; ch++) begin : g_chan
        channel_stats u_stats (
            .clk       (clk),
            .rst       (rst),
            .value     (chan_value),
            .strobe    (chan_strobe[ch]),
            .rec       (rec[ch]),
            .rec_valid (rec_valid[ch])
        );
    end

    packet_builder u_builder (
        .clk             (clk),
        .rst             (rst),
        .rec             (rec),
        .rec_valid       (rec_valid),
        .packet_taken    (packet_taken),
        .packet          (packet),
        .packet_valid    (packet_valid),
        .overwrite_pulse (overwrite_pulse)
    );

    spi_packet_tx u_spi (
        .clk          (clk),
        .rst          (rst),
        .sck          (sck),
        .load         (load),
        .sdo          (sdo),
        .done         (done),
        .packet       (packet),
        .packet_valid (packet_valid),
        .packet_taken (packet_taken)
    );

endmodule

`default_nettype wire

/* test/sensor_hub_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "sensor_hub_cfg.svh"

module sensor_hub_tb;

    localparam int WAIT_LIMIT = 1000;                     // Cycles before a wait gives up
    localparam int WIN_LEN    = 1 << `SH_WINDOW_LOG2;
    localparam int ROUND_LEN  = WIN_LEN * `SH_NUM_CHANNELS;
    localparam int PKT_BITS   = 8 * `SH_PACKET_BYTES;
    localparam int HALF_SCK   = 8;                        // clk cycles per sck half period

    logic                       clk;
    logic                       rst;
    sensor_hub_pkg::sample_t    sample_in;
    logic                       sample_valid;
    logic                       sck;
    logic                       load;
    logic                       sdo;
    logic                       done;
    logic                       overwrite_pulse;

    sensor_hub_pkg::chan_rec_t  newest [`SH_NUM_CHANNELS];   // Model of the last window sent
    int                         win_cnt [`SH_NUM_CHANNELS];  // Windows sent per channel
    int                         ovw_count = 0;
    sensor_hub_pkg::chan_rec_t  exp_q [$];                   // Pending record compares
    sensor_hub_pkg::chan_rec_t  got_q [$];
    string                      name_q [$];
    sensor_hub_pkg::tx_packet_u got_pkt;                     // As shifted in by the master

    sensor_hub_top dut (
        .clk             (clk),
        .rst             (rst),
        .sample_in       (sample_in),
        .sample_valid    (sample_valid),
        .sck             (sck),
        .load            (load),
        .sdo             (sdo),
        .done            (done),
        .overwrite_pulse (overwrite_pulse)
    );

    always #4 clk = ~clk;  // 8 ns period

    // Counts replaced records
    always @(negedge clk) begin
        if (!rst && overwrite_pulse) begin
            ovw_count++;
        end
    end

    // Records are compared as they come back from the SPI master
    always @(posedge clk) begin
        while (got_q.size() != 0) begin
            check_rec(name_q.pop_front(), exp_q.pop_front(), got_q.pop_front());
        end
    end

    task automatic stop_on_error(input string why);
        $display("CHECKS FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic check_rec(input string name, input sensor_hub_pkg::chan_rec_t exp,
                             input sensor_hub_pkg::chan_rec_t act);
        if (act !== exp) begin
            $write("FAILED %s expected avg=%h min=%h max=%h seq=%h ",
                   name, exp.avg, exp.min, exp.max, exp.seq);
            $display("actual avg=%h min=%h max=%h seq=%h", act.avg, act.min, act.max, act.seq);
            stop_on_error({"record mismatch in ", name});
        end
    endtask

    task automatic check_done(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED %s expected done=%b actual done=%b", name, exp, act);
            stop_on_error({"done level wrong in ", name});
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED %s expected %b actual %b", name, exp, act);
            stop_on_error({"bit wrong in ", name});
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            stop_on_error({"byte wrong in ", name});
        end
    endtask

    // Window statistics straight from the sample list
    function automatic sensor_hub_pkg::chan_rec_t ref_window(
        input logic [`SH_SAMPLE_W-1:0] win[$], input int seq);
        logic [31:0]               sum;
        logic [`SH_SAMPLE_W-1:0]   lo;
        logic [`SH_SAMPLE_W-1:0]   hi;
        sensor_hub_pkg::chan_rec_t r;
        sum = '0;
        lo  = '1;
        hi  = '0;
        foreach (win[i]) begin
            sum += win[i];
            lo = (win[i] < lo) ? win[i] : lo;
            hi = (win[i] > hi) ? win[i] : hi;
        end
        r.avg = `SH_SAMPLE_W'(sum / WIN_LEN);  // Truncating average
        r.min = lo;
        r.max = hi;
        r.seq = `SH_SAMPLE_W'(seq);
        return r;
    endfunction

    // Eight wire bytes per channel hold avg, min, max and seq with the high byte first
    function automatic logic [7:0] expected_byte(
        input sensor_hub_pkg::chan_rec_t recs [`SH_NUM_CHANNELS], input int idx);
        logic [`SH_SAMPLE_W-1:0] field;
        case ((idx % 8) / 2)
            0:       field = recs[idx / 8].avg;
            1:       field = recs[idx / 8].min;
            2:       field = recs[idx / 8].max;
            default: field = recs[idx / 8].seq;
        endcase
        return (idx % 2 == 0) ? field[15:8] : field[7:0];
    endfunction

    task automatic wait_done(input logic level, input string what);
        int cycles;
        cycles = 0;
        while (done !== level) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) stop_on_error({"timeout waiting for done in ", what});
        end
    endtask

    task automatic wait_overwrite();
        int cycles;
        cycles = 0;
        while (ovw_count == 0) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) stop_on_error("timeout waiting for overwrite_pulse");
        end
    endtask

    // Shuffled round of one window per channel
    // Fixed values give distinct fields in every channel
    task automatic send_round(input bit fixed, input bit check_idle);
        logic [sensor_hub_pkg::CHAN_W-1:0] sched_ch [ROUND_LEN];
        logic [`SH_SAMPLE_W-1:0]           sched_val [ROUND_LEN];
        logic [`SH_SAMPLE_W-1:0]           win [`SH_NUM_CHANNELS][$];
        logic [sensor_hub_pkg::CHAN_W-1:0] tmp_ch;
        logic [`SH_SAMPLE_W-1:0]           tmp_val;
        int                                j;
        for (int k = 0; k < ROUND_LEN; k++) begin
            sched_ch[k]  = sensor_hub_pkg::CHAN_W'(k / WIN_LEN);
            sched_val[k] = fixed ? `SH_SAMPLE_W'(16'h1000 * (k / WIN_LEN + 1)
                                   + 16'h0210 * (k % WIN_LEN) + k / WIN_LEN + 1)
                                 : `SH_SAMPLE_W'($urandom);
        end
        for (int k = ROUND_LEN - 1; k > 0; k--) begin  // Fisher-Yates interleave
            j            = int'($urandom % (k + 1));
            tmp_ch       = sched_ch[k];
            tmp_val      = sched_val[k];
            sched_ch[k]  = sched_ch[j];
            sched_val[k] = sched_val[j];
            sched_ch[j]  = tmp_ch;
            sched_val[j] = tmp_val;
        end
        for (int k = 0; k < ROUND_LEN; k++) begin
            @(negedge clk);
            if (check_idle) begin  // Nothing may leave before every window is complete
                check_done("idle before full round", 1'b0, done);
                check_bit("idle sdo before full round", 1'b0, sdo);
            end
            sample_in.chan  = sched_ch[k];
            sample_in.value = sched_val[k];
            sample_valid    = 1'b1;
            win[sched_ch[k]].push_back(sched_val[k]);
        end
        @(negedge clk);
        sample_valid = 1'b0;
        for (int ch = 0; ch < `SH_NUM_CHANNELS; ch++) begin
            newest[ch] = ref_window(win[ch], win_cnt[ch]);
            win_cnt[ch]++;
        end
    endtask

    // Mode 0 master samples sdo at the end of each low phase
    task automatic spi_read_packet(output sensor_hub_pkg::tx_packet_u pkt);
        logic [PKT_BITS-1:0] rx;
        rx = '0;
        for (int b = 0; b < PKT_BITS; b++) begin
            repeat (HALF_SCK) @(negedge clk);
            rx  = {rx[PKT_BITS-2:0], sdo};  // First bit lands in the MSB
            sck = 1'b1;
            repeat (HALF_SCK) @(negedge clk);
            sck = 1'b0;                       // Slave shifts on this edge
        end
        pkt = rx;
    endtask

    task automatic spi_extra_edges(input int n);
        for (int e = 0; e < n; e++) begin
            repeat (HALF_SCK) @(negedge clk);
            check_bit("sdo after last bit", 1'b0, sdo);
            sck = 1'b1;
            repeat (HALF_SCK) @(negedge clk);
            sck = 1'b0;
        end
        repeat (HALF_SCK) @(negedge clk);
        check_bit("sdo after extra edges", 1'b0, sdo);
    endtask

    task automatic ack_packet(input string what);
        @(negedge clk);
        load = 1'b1;
        wait_done(1'b0, what);  // Rising load drops done
        repeat (4) @(negedge clk);
        load = 1'b0;
        repeat (4) @(negedge clk);  // Let the low level pass the synchronizer
    endtask

    task automatic queue_packet(input string tag, input sensor_hub_pkg::tx_packet_u pkt);
        for (int ch = 0; ch < `SH_NUM_CHANNELS; ch++) begin
            name_q.push_back($sformatf("%s ch%0d", tag, ch));
            exp_q.push_back(newest[ch]);
            got_q.push_back(pkt.chan[ch]);
        end
    endtask

    initial begin
        void'($urandom(32'he084_45e3));
        clk          = 1'b0;
        rst          = 1'b1;
        sample_in    = '0;
        sample_valid = 1'b0;
        sck          = 1'b0;
        load         = 1'b0;
        foreach (win_cnt[ch]) win_cnt[ch] = 0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_done("reset done", 1'b0, done);
        check_bit("reset sdo", 1'b0, sdo);

        // First packet from random windows with seq 0
        send_round(1'b0, 1'b1);
        wait_done(1'b1, "first packet");
        check_bit("first bit with done", newest[0].avg[15], sdo);
        spi_read_packet(got_pkt);
        queue_packet("random window", got_pkt);
        ack_packet("first acknowledge");

        // Second round with fixed values checks seq 1 and wire byte order
        send_round(1'b1, 1'b1);
        wait_done(1'b1, "second packet");
        spi_read_packet(got_pkt);
        queue_packet("fixed window", got_pkt);
        for (int b = 0; b < `SH_PACKET_BYTES; b++) begin
            check_byte($sformatf("byte order %0d", b), expected_byte(newest, b), got_pkt.bytes[b]);
        end

        // Two more windows while the second packet still waits
        check_bit("no overwrite before back-pressure", 1'b0, ovw_count != 0);
        send_round(1'b0, 1'b0);
        send_round(1'b0, 1'b0);
        wait_overwrite();
        check_done("packet held during back-pressure", 1'b1, done);
        ack_packet("stale packet acknowledge");
        wait_done(1'b1, "newest packet");
        spi_read_packet(got_pkt);
        queue_packet("newest window", got_pkt);
        spi_extra_edges(4);
        ack_packet("final acknowledge");

        for (int c = 0; got_q.size() != 0; c++) begin  // Let the compare process finish
            if (c > WAIT_LIMIT) stop_on_error("timeout waiting for record compares");
            @(negedge clk);
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+include
src/sensor_hub_pkg.sv
src/sample_router.sv
src/channel_stats.sv
src/packet_builder.sv
src/spi_packet_tx.sv
src/sensor_hub_top.sv
test/sensor_hub_tb.sv

/* Bender.yml */
package:
  name: sensor_hub

sources:
  - include_dirs:
      - include
    files:
      - src/sensor_hub_pkg.sv
      - src/sample_router.sv
      - src/channel_stats.sv
      - src/packet_builder.sv
      - src/spi_packet_tx.sv
      - src/sensor_hub_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/sensor_hub_tb.sv
